// File: Bender.yml
package:
  name: wfd_top

sources:
  # package first, then the blocks, then the top level
  - design/wfd_pkg.sv
  - design/trigger_manager.sv
  - design/trig_num_fifo.sv
  - design/chan_rx_arbiter.sv
  - design/fill_readout.sv
  - design/wfd_top.sv

  # testbench, top module tb_wfd_top
  - target: test
    files:
      - testbench/tb_wfd_top.sv

// File: design/chan_rx_arbiter.sv
// round-robin arbiter putting one whole channel packet at a time onto the shared readout bus
`timescale 1ns/10ps

module chan_rx_arbiter (
    input  logic                clk125,
    input  logic                rst_n,
    input  wfd_pkg::chan_mask_t chan_valid,
    input  wfd_pkg::chan_beat_t chan_beat [wfd_pkg::num_chan],
    output wfd_pkg::chan_mask_t chan_ready,
    output logic                bus_valid,
    output wfd_pkg::chan_beat_t bus_beat,
    output wfd_pkg::chan_id_t   bus_id,    // channel that owns the bus
    input  logic                bus_ready
);

    wfd_pkg::chan_id_t rr_ptr; // search starts here
    wfd_pkg::chan_id_t grant;  // locked channel
    logic              locked; // a packet is in flight
    wfd_pkg::chan_id_t pick;
    logic              pick_hit;

    ////////////////////////////////////////////////////////////////////////////
    // next requester in round-robin order

    always_comb begin
        int unsigned idx;
        pick     = rr_ptr;
        pick_hit = 1'b0;
        for (int i = 0; i < wfd_pkg::num_chan; i++) begin
            idx = rr_ptr + i;
            if (idx >= wfd_pkg::num_chan) idx = idx - wfd_pkg::num_chan; // wrap past ch 4
            if (!pick_hit && chan_valid[idx]) begin
                pick_hit = 1'b1;
                pick     = wfd_pkg::chan_id_t'(idx);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // packet lock

    always_ff @(posedge clk125 or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= '0; // channel 0 first
            grant  <= '0;
            locked <= 1'b0;
        end else if (!locked) begin
            if (pick_hit) begin
                locked <= 1'b1;
                grant  <= pick;
                // start after the winner next time
                rr_ptr <= (pick == wfd_pkg::num_chan - 1) ? '0 : pick + 1'b1;
            end
        end else if (bus_valid && bus_ready && bus_beat.last) begin
            locked <= 1'b0; // whole packet gone, rearbitrate
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // bus mux

    assign bus_valid = locked & chan_valid[grant];
    assign bus_beat  = chan_beat[grant];
    assign bus_id    = grant;

    // only the owner sees ready
    always_comb begin
        chan_ready        = '0;
        chan_ready[grant] = locked & bus_ready;
    end

endmodule

// File: design/fill_readout.sv
// readout engine building daq header, data and trailer words from a trigger number and packets
`timescale 1ns/10ps

module fill_readout (
    input  logic                clk125,
    input  logic                rst_n,
    input  wfd_pkg::chan_mask_t chan_en,
    // trigger number fifo
    input  logic                num_valid,
    output logic                num_ready,
    input  wfd_pkg::trig_num_t  trig_num,
    // shared channel bus
    input  logic                bus_valid,
    input  wfd_pkg::chan_beat_t bus_beat,
    input  wfd_pkg::chan_id_t   bus_id,
    output logic                bus_ready,
    // amc13 daq link
    output logic                daq_valid,
    output wfd_pkg::daq_beat_t  daq_beat,
    input  logic                daq_ready
);

    wfd_pkg::ro_state_t    state;
    wfd_pkg::trig_num_t    cur_num;  // fill being read out
    wfd_pkg::chan_id_t     pkt_cnt;  // packets finished this fill
    wfd_pkg::chan_id_t     n_en;     // packets expected
    wfd_pkg::word_cnt_t    word_cnt; // data words sent
    wfd_pkg::daq_header_t  hdr;
    wfd_pkg::daq_data_t    dat;
    wfd_pkg::daq_trailer_t trl;
    logic                  beat_xfer;
    logic                  daq_xfer;

    assign n_en = wfd_pkg::chan_id_t'($countones(chan_en));

    // take a number only when idle and something is enabled
    assign num_ready = (state == wfd_pkg::ro_idle) && (chan_en != '0);
    assign bus_ready = (state == wfd_pkg::ro_data) && daq_ready; // stall reaches the channels
    assign beat_xfer = bus_valid & bus_ready;
    assign daq_xfer  = daq_valid & daq_ready;

    ////////////////////////////////////////////////////////////////////////////
    // daq word layouts

    always_comb begin
        hdr          = '0;
        hdr.tag      = wfd_pkg::daq_tag_header;
        hdr.chan_en  = chan_en;
        hdr.trig_num = cur_num;

        dat          = '0;
        dat.tag      = wfd_pkg::daq_tag_data;
        dat.chan_id  = bus_id;
        dat.payload  = bus_beat.data;

        trl          = '0;
        trl.tag      = wfd_pkg::daq_tag_trailer;
        trl.trig_num = cur_num;
        trl.word_cnt = word_cnt;
    end

    // output mux, data words pass straight from the bus
    always_comb begin
        daq_valid = 1'b0;
        daq_beat  = '0;
        case (state)
            wfd_pkg::ro_header: begin
                daq_valid       = 1'b1;
                daq_beat.header = 1'b1;
                daq_beat.data   = wfd_pkg::daq_word_t'(hdr);
            end
            wfd_pkg::ro_data: begin
                daq_valid     = bus_valid;
                daq_beat.data = wfd_pkg::daq_word_t'(dat);
            end
            wfd_pkg::ro_trailer: begin
                daq_valid        = 1'b1;
                daq_beat.trailer = 1'b1;
                daq_beat.data    = wfd_pkg::daq_word_t'(trl);
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // fill sequencing

    always_ff @(posedge clk125) begin
        if (num_valid && num_ready) cur_num <= trig_num; // latched on pop
    end

    always_ff @(posedge clk125 or negedge rst_n) begin
        if (!rst_n) begin
            state    <= wfd_pkg::ro_idle;
            pkt_cnt  <= '0;
            word_cnt <= '0;
        end else begin
            case (state)
                wfd_pkg::ro_idle: begin
                    if (num_valid && num_ready) state <= wfd_pkg::ro_header;
                end
                wfd_pkg::ro_header: begin
                    if (daq_xfer) begin
                        state    <= wfd_pkg::ro_data;
                        pkt_cnt  <= '0;
                        word_cnt <= '0;
                    end
                end
                wfd_pkg::ro_data: begin
                    if (beat_xfer) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (bus_beat.last) begin
                            pkt_cnt <= pkt_cnt + 1'b1;
                            // last packet of the fill
                            if (pkt_cnt == n_en - 1'b1) state <= wfd_pkg::ro_trailer;
                        end
                    end
                end
                wfd_pkg::ro_trailer: begin
                    if (daq_xfer) state <= wfd_pkg::ro_idle; // fill closed
                end
                default: state <= wfd_pkg::ro_idle;
            endcase
        end
    end

endmodule

// File: design/trig_num_fifo.sv
// small circular buffer of trigger numbers between the trigger manager and the readout engine
`timescale 1ns/10ps

module trig_num_fifo (
    input  logic               clk125,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,  // low when full
    input  wfd_pkg::trig_num_t in_num,
    output logic               out_valid, // low when empty
    input  logic               out_ready,
    output wfd_pkg::trig_num_t out_num
);

    wfd_pkg::trig_num_t mem [wfd_pkg::trig_fifo_depth];

    logic [$clog2(wfd_pkg::trig_fifo_depth)-1:0]   wr_ptr;
    logic [$clog2(wfd_pkg::trig_fifo_depth)-1:0]   rd_ptr;
    logic [$clog2(wfd_pkg::trig_fifo_depth+1)-1:0] count;  // entries held
    logic                                          push;
    logic                                          pop;

    assign in_ready  = (count != wfd_pkg::trig_fifo_depth);
    assign out_valid = (count != 0);
    assign out_num   = mem[rd_ptr];  // head entry, shows up the cycle after its write

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    // storage
    always_ff @(posedge clk125) begin
        if (push) mem[wr_ptr] <= in_num;
    end

    always_ff @(posedge clk125 or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == wfd_pkg::trig_fifo_depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == wfd_pkg::trig_fifo_depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

// File: design/trigger_manager.sv
// trigger manager that syncs the front panel trigger, issues channel go pulses and numbers fills
`timescale 1ns/10ps

module trigger_manager (
    input  logic                clk125,
    input  logic                rst_n,
    input  logic                ext_trig,  // async, front panel
    input  wfd_pkg::chan_mask_t chan_en,
    input  wfd_pkg::chan_mask_t acq_dones, // level from each channel
    output wfd_pkg::chan_mask_t acq_trigs, // one-cycle go
    output wfd_pkg::chan_mask_t trig_arm,
    output logic                num_valid, // push toward trigger number fifo
    input  logic                num_ready,
    output wfd_pkg::trig_num_t  trig_num
);

    logic               trig_meta;   // first sync stage
    logic               trig_sync;   // second sync stage
    logic               trig_sync_d; // for edge detect
    logic               trig_rise;
    logic               accept;
    logic               all_done;
    wfd_pkg::tm_state_t state;
    wfd_pkg::trig_num_t trig_cnt;    // number of the next trigger

    ////////////////////////////////////////////////////////////////////////////
    // synchronizer and rising edge

    always_ff @(posedge clk125 or negedge rst_n) begin
        if (!rst_n) begin
            trig_meta   <= 1'b0;
            trig_sync   <= 1'b0;
            trig_sync_d <= 1'b0;
        end else begin
            trig_meta   <= ext_trig;
            trig_sync   <= trig_meta;
            trig_sync_d <= trig_sync;
        end
    end

    assign trig_rise = trig_sync & ~trig_sync_d;

    // dropped when busy, nothing enabled, or no room for the number
    assign accept = trig_rise && (state == wfd_pkg::tm_idle) && (chan_en != '0) && num_ready;

    // disabled channels count as done
    assign all_done = ((acq_dones & chan_en) == chan_en);

    ////////////////////////////////////////////////////////////////////////////
    // go/done sequencing

    always_ff @(posedge clk125 or negedge rst_n) begin
        if (!rst_n) begin
            state     <= wfd_pkg::tm_idle;
            acq_trigs <= '0;
        end else begin
            acq_trigs <= accept ? chan_en : '0; // lands on the third edge
            case (state)
                wfd_pkg::tm_idle: begin
                    if (accept) state <= wfd_pkg::tm_wait_done;
                end
                wfd_pkg::tm_wait_done: begin
                    if (all_done) state <= wfd_pkg::tm_idle; // channels finished
                end
                default: state <= wfd_pkg::tm_idle;
            endcase
        end
    end

    // channels keep their buffers running only while we can take a trigger
    assign trig_arm = (state == wfd_pkg::tm_idle) ? chan_en : '0;

    ////////////////////////////////////////////////////////////////////////////
    // trigger numbering

    always_ff @(posedge clk125 or negedge rst_n) begin
        if (!rst_n) begin
            num_valid <= 1'b0;
            trig_cnt  <= '0;
        end else begin
            if (accept) begin
                num_valid <= 1'b1;       // push alongside the go pulse
            end else if (num_ready) begin
                num_valid <= 1'b0;
            end
            if (num_valid && num_ready) begin
                trig_cnt <= trig_cnt + 1'b1; // next fill gets the next number
            end
        end
    end

    assign trig_num = trig_cnt;

endmodule

// File: design/wfd_pkg.sv
// shared widths, stream beats, daq word layouts and fsm states of the wfd5 trigger/readout core
package wfd_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // channel side

    localparam int num_chan = 5;              // channel fpgas on the board

    typedef logic [num_chan-1:0] chan_mask_t; // enable, go, done, arm
    typedef logic [2:0]          chan_id_t;   // channel index 0..4
    typedef logic [23:0]         trig_num_t;  // trigger (fill) number
    typedef logic [31:0]         chan_word_t; // payload from a channel link

    // one beat of a channel packet or of the shared readout bus
    typedef struct packed {
        chan_word_t data;
        logic       last; // final beat of the packet
    } chan_beat_t;

    localparam int trig_fifo_depth = 4; // trigger numbers waiting for readout

    ////////////////////////////////////////////////////////////////////////////
    // daq link side

    typedef logic [63:0] daq_word_t;
    typedef logic [7:0]  daq_tag_t;   // sits in bits 63..56 of every word

    localparam daq_tag_t daq_tag_header  = 8'hA5;
    localparam daq_tag_t daq_tag_data    = 8'hD0;
    localparam daq_tag_t daq_tag_trailer = 8'h5A;

    // filler widths so each layout comes out at exactly one daq word
    localparam int daq_hdr_pad_w  = $bits(daq_word_t) - $bits(daq_tag_t) - num_chan
                                    - $bits(trig_num_t);
    localparam int daq_data_pad_w = $bits(daq_word_t) - $bits(daq_tag_t) - $bits(chan_id_t)
                                    - $bits(chan_word_t);
    localparam int daq_cnt_w      = $bits(daq_word_t) - $bits(daq_tag_t) - $bits(trig_num_t);

    typedef logic [daq_cnt_w-1:0] word_cnt_t; // data words in one fill

    typedef struct packed {
        daq_tag_t                 tag;
        logic [daq_hdr_pad_w-1:0] pad;
        chan_mask_t               chan_en;  // bits 28..24
        trig_num_t                trig_num; // bits 23..0
    } daq_header_t;

    typedef struct packed {
        daq_tag_t                  tag;
        logic [daq_data_pad_w-1:0] pad;
        chan_id_t                  chan_id; // bits 34..32
        chan_word_t                payload;
    } daq_data_t;

    typedef struct packed {
        daq_tag_t  tag;
        trig_num_t trig_num; // bits 55..32
        word_cnt_t word_cnt;
    } daq_trailer_t;

    // word toward the amc13 link, with its framing flags
    typedef struct packed {
        logic      header;
        logic      trailer;
        daq_word_t data;
    } daq_beat_t;

    ////////////////////////////////////////////////////////////////////////////
    // fsm states

    typedef enum logic [0:0] {tm_idle, tm_wait_done} tm_state_t;
    typedef enum logic [1:0] {ro_idle, ro_header, ro_data, ro_trailer} ro_state_t;

endpackage

// File: design/wfd_top.sv
// trigger and readout core of the wfd5 master, from front panel trigger to daq link words
`timescale 1ns/10ps

module wfd_top (
    input  logic                clk125,
    input  logic                rst_n,
    input  logic                ext_trig,
    input  wfd_pkg::chan_mask_t chan_en,    // static while a fill is open
    input  wfd_pkg::chan_mask_t acq_dones,
    output wfd_pkg::chan_mask_t acq_trigs,
    output wfd_pkg::chan_mask_t trig_arm,
    input  wfd_pkg::chan_mask_t chan_valid,
    input  wfd_pkg::chan_beat_t chan_beat [wfd_pkg::num_chan],
    output wfd_pkg::chan_mask_t chan_ready,
    output logic                daq_valid,
    output wfd_pkg::daq_beat_t  daq_beat,
    input  logic                daq_ready
);

    // trigger manager to fifo
    logic                tm_num_valid;
    logic                tm_num_ready;
    wfd_pkg::trig_num_t  tm_num;

    // fifo to readout
    logic                fifo_num_valid;
    logic                fifo_num_ready;
    wfd_pkg::trig_num_t  fifo_num;

    // shared channel bus
    logic                bus_valid;
    logic                bus_ready;
    wfd_pkg::chan_beat_t bus_beat;
    wfd_pkg::chan_id_t   bus_id;

    ////////////////////////////////////////////////////////////////////////////
    // trigger path

    trigger_manager i_trig_mgr (
        .clk125    (clk125),
        .rst_n     (rst_n),
        .ext_trig  (ext_trig),
        .chan_en   (chan_en),
        .acq_dones (acq_dones),
        .acq_trigs (acq_trigs),
        .trig_arm  (trig_arm),
        .num_valid (tm_num_valid),
        .num_ready (tm_num_ready), // fifo has room
        .trig_num  (tm_num)
    );

    trig_num_fifo i_trig_fifo (
        .clk125    (clk125),
        .rst_n     (rst_n),
        .in_valid  (tm_num_valid),
        .in_ready  (tm_num_ready),
        .in_num    (tm_num),
        .out_valid (fifo_num_valid),
        .out_ready (fifo_num_ready),
        .out_num   (fifo_num)
    );

    ////////////////////////////////////////////////////////////////////////////
    // readout path

    chan_rx_arbiter i_arbiter (
        .clk125     (clk125),
        .rst_n      (rst_n),
        .chan_valid (chan_valid),
        .chan_beat  (chan_beat),
        .chan_ready (chan_ready),
        .bus_valid  (bus_valid),
        .bus_beat   (bus_beat),
        .bus_id     (bus_id),
        .bus_ready  (bus_ready)
    );

    fill_readout i_readout (
        .clk125    (clk125),
        .rst_n     (rst_n),
        .chan_en   (chan_en),
        .num_valid (fifo_num_valid),
        .num_ready (fifo_num_ready),
        .trig_num  (fifo_num),
        .bus_valid (bus_valid),
        .bus_beat  (bus_beat),
        .bus_id    (bus_id),
        .bus_ready (bus_ready),
        .daq_valid (daq_valid),
        .daq_beat  (daq_beat),
        .daq_ready (daq_ready)
    );

endmodule

// File: src.f
design/wfd_pkg.sv
design/trigger_manager.sv
design/trig_num_fifo.sv
design/chan_rx_arbiter.sv
design/fill_readout.sv
design/wfd_top.sv
testbench/tb_wfd_top.sv

// File: testbench/tb_wfd_top.sv
// testbench for the wfd5 trigger/readout core with table driven fills checked against a scoreboard
`timescale 1ns/10ps

module tb_wfd_top;

    // one fill with its enable mask, packet length per channel (ch0 in the low nibble),
    // daq_ready pattern, and whether a second trigger hits while channels are busy
    typedef struct packed {
        wfd_pkg::chan_mask_t mask;
        logic [19:0]         lens;
        logic [15:0]         stall;
        logic                retrig;
    } row_t;

    localparam int num_rows = 7;

    logic                clk125;
    logic                rst_n;
    logic                ext_trig;
    wfd_pkg::chan_mask_t chan_en;
    wfd_pkg::chan_mask_t acq_dones;
    wfd_pkg::chan_mask_t acq_trigs;
    wfd_pkg::chan_mask_t trig_arm;
    wfd_pkg::chan_mask_t chan_valid;
    wfd_pkg::chan_beat_t chan_beat [wfd_pkg::num_chan];
    wfd_pkg::chan_mask_t chan_ready;
    logic                daq_valid;
    wfd_pkg::daq_beat_t  daq_beat;
    logic                daq_ready;

    row_t                rows [num_rows];
    row_t                cur;                         // row being applied
    int                  seed;
    int                  mismatch_cnt;
    int                  other_cnt;
    int                  go_cnt;                      // go pulses seen = next trigger number
    int                  fills_done;                  // trailers seen
    bit                  hung;
    wfd_pkg::chan_mask_t chan_took;                   // beats taken at the last edge
    int                  ch_wait [wfd_pkg::num_chan]; // cycles until done rises
    int                  ch_idx  [wfd_pkg::num_chan]; // beat on offer
    int                  ch_trig [wfd_pkg::num_chan]; // trigger the packet belongs to
    logic [3:0]          stall_cyc;
    bit                  in_fill;                     // scoreboard between header and trailer
    int                  rx_idx  [wfd_pkg::num_chan]; // words received per channel
    int                  cur_id;                      // channel of the packet on the link
    int                  rx_words;
    bit                  hold_pending;                // word offered but not taken
    wfd_pkg::daq_beat_t  hold_beat;

    wfd_top i_dut (
        .clk125     (clk125),
        .rst_n      (rst_n),
        .ext_trig   (ext_trig),
        .chan_en    (chan_en),
        .acq_dones  (acq_dones),
        .acq_trigs  (acq_trigs),
        .trig_arm   (trig_arm),
        .chan_valid (chan_valid),
        .chan_beat  (chan_beat),
        .chan_ready (chan_ready),
        .daq_valid  (daq_valid),
        .daq_beat   (daq_beat),
        .daq_ready  (daq_ready)
    );

    always #2 clk125 = ~clk125; // 250 MHz sim clock stands in for clk125

    ////////////////////////////////////////////////////////////////////////////
    // helpers and compare tasks

    function automatic wfd_pkg::chan_word_t payload(int t, int c, int k);
        return wfd_pkg::chan_word_t'(t * 256 + c * 16 + k);
    endfunction

    function automatic int pkt_len(row_t r, int c);
        return int'(r.lens[4*c +: 4]);
    endfunction

    function automatic int fill_words(row_t r);
        int sum;
        sum = 0;
        for (int c = 0; c < wfd_pkg::num_chan; c++) begin
            if (r.mask[c]) sum += pkt_len(r, c);
        end
        return sum;
    endfunction

    function automatic wfd_pkg::chan_beat_t make_beat(int t, int c, int k, int len);
        wfd_pkg::chan_beat_t b;
        b.data = payload(t, c, k);
        b.last = (k == len - 1);
        return b;
    endfunction

    task automatic check_word(input wfd_pkg::daq_word_t got, input wfd_pkg::daq_word_t exp,
                              input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_mask(input wfd_pkg::chan_mask_t got, input wfd_pkg::chan_mask_t exp,
                              input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_num(input wfd_pkg::trig_num_t got, input wfd_pkg::trig_num_t exp,
                             input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        other_cnt++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic check_quiet();
        check_mask(acq_trigs, '0, "acq_trigs after reset");
        check_mask(trig_arm, chan_en, "trig_arm after reset");
        check_mask(chan_ready, '0, "chan_ready after reset");
        if (daq_valid !== 1'b0) report_error("daq_valid is high right after reset");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // channel models and go monitor driven on the falling edge

    always @(posedge clk125) chan_took <= chan_valid & chan_ready;

    always @(negedge clk125) begin
        stall_cyc = stall_cyc + 1'b1;
        daq_ready = cur.stall[stall_cyc];      // stall pattern repeats every 16 cycles
        if (acq_trigs != '0) begin
            check_mask(acq_trigs, cur.mask, "go pulse");
            go_cnt <= go_cnt + 1;
        end
        for (int c = 0; c < wfd_pkg::num_chan; c++) begin
            if (chan_took[c]) begin
                ch_idx[c]++;
                if (ch_idx[c] >= pkt_len(cur, c)) chan_valid[c] = 1'b0; // packet gone
                else chan_beat[c] = make_beat(ch_trig[c], c, ch_idx[c], pkt_len(cur, c));
            end
            if (acq_trigs[c]) begin
                acq_dones[c] = 1'b0;           // done falls on go
                ch_trig[c]   = go_cnt;
                ch_wait[c]   = 20 + ($random(seed) & 15);
            end else if (ch_wait[c] > 0) begin
                ch_wait[c]--;
                if (ch_wait[c] == 0) begin     // acquisition over so the packet goes out
                    acq_dones[c]  = 1'b1;
                    ch_idx[c]     = 0;
                    chan_valid[c] = 1'b1;
                    chan_beat[c]  = make_beat(ch_trig[c], c, 0, pkt_len(cur, c));
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // daq scoreboard sampled on the rising edge

    always @(posedge clk125) begin
        wfd_pkg::daq_word_t w;
        int                 id;
        w = daq_beat.data;
        if (hold_pending) begin
            if (!daq_valid) begin
                report_error("daq_valid dropped before the word was taken");
            end else begin
                check_word(w, hold_beat.data, "word held under stall");
                if (daq_beat.header !== hold_beat.header ||
                    daq_beat.trailer !== hold_beat.trailer)
                    report_error("framing flags changed while the word was held");
            end
        end
        hold_pending = daq_valid && !daq_ready;
        hold_beat    = daq_beat;
        if (daq_valid && daq_ready) begin
            if (!in_fill) begin
                if (daq_beat.header !== 1'b1 || daq_beat.trailer !== 1'b0)
                    report_error("a header word was due but the flags disagree");
                check_num(w[23:0], wfd_pkg::trig_num_t'(fills_done), "header trigger number");
                check_mask(w[28:24], cur.mask, "header channel mask");
                check_word(w, {8'hA5, 27'd0, cur.mask, wfd_pkg::trig_num_t'(fills_done)},
                           "header word");
                in_fill  = 1'b1;
                rx_words = 0;
                cur_id   = -1;
                for (int c = 0; c < wfd_pkg::num_chan; c++) rx_idx[c] = 0;
            end else if (rx_words < fill_words(cur)) begin
                id = int'(w[34:32]);
                if (daq_beat.header !== 1'b0 || daq_beat.trailer !== 1'b0)
                    report_error("a data word carries a framing flag");
                if (id >= wfd_pkg::num_chan || !cur.mask[id]) begin
                    report_error($sformatf("data word from channel %0d, not enabled", id));
                end else begin
                    if (id != cur_id) begin    // a new packet starts
                        if (cur_id >= 0 && rx_idx[cur_id] != pkt_len(cur, cur_id))
                            report_error($sformatf("packet of channel %0d cut off", cur_id));
                        if (rx_idx[id] != 0)
                            report_error($sformatf("channel %0d sent a second packet", id));
                        cur_id = id;
                    end
                    check_word(w, {8'hD0, 21'd0, 3'(id), payload(fills_done, id, rx_idx[id])},
                               "data word");
                    rx_idx[id]++;
                end
                rx_words++;
            end else begin
                if (daq_beat.header !== 1'b0 || daq_beat.trailer !== 1'b1)
                    report_error("a trailer word was due but the flags disagree");
                for (int c = 0; c < wfd_pkg::num_chan; c++) begin
                    if (cur.mask[c] && rx_idx[c] != pkt_len(cur, c))
                        report_error($sformatf("packet of channel %0d incomplete", c));
                end
                check_word(w, {8'h5A, wfd_pkg::trig_num_t'(fills_done),
                               wfd_pkg::word_cnt_t'(fill_words(cur))}, "trailer word");
                in_fill = 1'b0;
                fills_done++;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    task automatic load_table();
        //          mask    lens       stall     retrig
        rows[0] = {5'h01, 20'h00003, 16'hffff, 1'b0}; // ch0 alone
        rows[1] = {5'h1f, 20'h54321, 16'hffff, 1'b1}; // all five
        rows[2] = {5'h15, 20'h70604, 16'ha5a5, 1'b0};
        rows[3] = {5'h10, 20'h80000, 16'h3333, 1'b1}; // ch4 alone
        rows[4] = {5'h1f, 20'h28f13, 16'h8421, 1'b0}; // heavy stall
        rows[5] = {5'h0a, 20'h05020, 16'hf0f0, 1'b1};
        rows[6] = {5'h1f, 20'h11111, 16'h7ffe, 1'b0}; // one beat packets
    endtask

    task automatic run_fill(input row_t r);
        int base;
        int n;
        @(negedge clk125);
        cur     = r;
        chan_en = r.mask;
        @(negedge clk125);
        check_mask(trig_arm, r.mask, "trig_arm while idle");
        base     = go_cnt;
        ext_trig = 1'b1;
        n        = 0;
        while (go_cnt == base && n < 16) begin
            @(negedge clk125);
            n++;
        end
        ext_trig = 1'b0;
        if (go_cnt == base) begin
            report_error("timeout waiting for the go pulse");
            hung = 1'b1;
        end else begin
            // go shows at the falling edge after the third rising edge, counted one later
            if (n != 4) report_error("go pulse not on the third clock edge after the trigger");
            if (r.retrig) begin                // channels still busy so this one is dropped
                repeat (2) @(negedge clk125);
                check_mask(trig_arm, '0, "trig_arm while waiting for done");
                ext_trig = 1'b1;
                repeat (3) @(negedge clk125);
                ext_trig = 1'b0;
            end
            n = 0;
            while (fills_done <= base && n < 3000) begin
                @(negedge clk125);
                n++;
            end
            if (fills_done <= base) begin
                report_error("timeout waiting for the trailer of a fill");
                hung = 1'b1;
            end else begin
                check_num(wfd_pkg::trig_num_t'(go_cnt), wfd_pkg::trig_num_t'(base + 1),
                          "go pulses for one trigger");
            end
        end
        repeat (4) @(negedge clk125);
    endtask

    initial begin
        clk125       = 1'b0;
        rst_n        = 1'b0;
        ext_trig     = 1'b0;
        chan_en      = 5'h1f;
        acq_dones    = '0;
        chan_valid   = '0;
        daq_ready    = 1'b0;
        cur          = '0;
        stall_cyc    = '0;
        seed         = 32'he49b_c05a;
        mismatch_cnt = 0;
        other_cnt    = 0;
        go_cnt       = 0;
        fills_done   = 0;
        hung         = 1'b0;
        in_fill      = 1'b0;
        hold_pending = 1'b0;
        cur_id       = -1;
        for (int c = 0; c < wfd_pkg::num_chan; c++) begin
            chan_beat[c] = '0;
            ch_wait[c]   = 0;
            ch_idx[c]    = 0;
            ch_trig[c]   = 0;
        end
        load_table();
        repeat (5) begin                       // reset held 5 cycles
            @(negedge clk125);
            check_quiet();
        end
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk125);
            check_quiet();
        end
        for (int r = 0; r < num_rows && !hung; r++) run_fill(rows[r]);
        @(negedge clk125);
        check_num(wfd_pkg::trig_num_t'(go_cnt), wfd_pkg::trig_num_t'(num_rows),
                  "accepted trigger count");
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (!hung && mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
